// File: logic/gc_bank_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module gc_bank_dispatch (
    input  wire logic                            i_head_valid,
    input  wire gc_pkg::gc_entry_t               i_head,
    input  wire logic                            i_order_full,
    input  wire logic [gc_pkg::NUM_BANKS-1:0]    i_bank_ready,
    output logic                                 o_pop,
    output logic                                 o_order_push,
    output gc_pkg::bank_t                        o_order_bank,
    output logic [gc_pkg::NUM_BANKS-1:0]         o_bank_cmd_valid,
    output gc_pkg::op_e                          o_bank_op,
    output logic [gc_pkg::ROW_BITS-1:0]          o_bank_row,
    output logic [gc_pkg::COL_BITS-1:0]          o_bank_col,
    output logic [gc_pkg::WORD_BITS-1:0]         o_bank_write_data
);

    logic can_issue;

    // a full order queue stalls every bank, writes included
    assign can_issue = i_head_valid && !i_order_full;

    always_comb
    begin
        for (int b = 0; b < gc_pkg::NUM_BANKS; b++)
        begin
            o_bank_cmd_valid[b] = can_issue && i_bank_ready[b]
                                  && (i_head.cmd.bank == gc_pkg::bank_t'(b));
        end
    end

    // valid already includes ready, so any valid is a transfer
    assign o_pop        = |o_bank_cmd_valid;
    assign o_order_push = o_pop && (i_head.cmd.op == gc_pkg::OP_READ);
    assign o_order_bank = i_head.cmd.bank;

    // shared command fields
    assign o_bank_op         = i_head.cmd.op;
    assign o_bank_row        = i_head.cmd.row;
    assign o_bank_col        = i_head.cmd.col;
    assign o_bank_write_data = i_head.data;

endmodule

`default_nettype wire

// File: logic/gc_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module gc_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 8
) (
    input  wire logic i_clk,
    input  wire logic i_rst_n,
    input  wire logic i_push,
    input  wire T     i_data,
    input  wire logic i_pop,
    output T          o_data,
    output logic      o_empty,
    output logic      o_full
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    T                    mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;

    // head shown ahead of the pop
    assign o_data  = mem[rd_ptr];
    assign o_empty = (count == '0);
    assign o_full  = (count == CNT_BITS'(DEPTH));

    always_ff @(posedge i_clk)
    begin
        if (i_push)
        begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (i_push)
            begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (i_pop)
            begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // count moves only when exactly one side is active
            if (i_push && !i_pop)
            begin
                count <= count + 1'b1;
            end
            else if (i_pop && !i_push)
            begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/gc_global_controller.sv
`timescale 1ns/1ps
`default_nettype none

module gc_global_controller #(
    parameter int QUEUE_DEPTH = gc_pkg::QUEUE_DEPTH_DEF,
    parameter int SCHED_DEPTH = gc_pkg::SCHED_DEPTH_DEF,
    parameter int ORDER_DEPTH = gc_pkg::ORDER_DEPTH_DEF
) (
    input  wire logic                                            i_clk,
    input  wire logic                                            i_rst_n,
    // request channel
    input  wire logic                                            i_cmd_valid,
    input  wire gc_pkg::op_e                                     i_cmd_op,
    input  wire gc_pkg::bank_t                                   i_cmd_bank,
    input  wire logic [gc_pkg::ROW_BITS-1:0]                     i_cmd_row,
    input  wire logic [gc_pkg::COL_BITS-1:0]                     i_cmd_col,
    input  wire logic [gc_pkg::WORD_BITS-1:0]                    i_write_data,
    output logic                                                 o_ready,
    // bank command channel
    input  wire logic [gc_pkg::NUM_BANKS-1:0]                    i_bank_ready,
    output logic [gc_pkg::NUM_BANKS-1:0]                         o_bank_cmd_valid,
    output gc_pkg::op_e                                          o_bank_op,
    output logic [gc_pkg::ROW_BITS-1:0]                          o_bank_row,
    output logic [gc_pkg::COL_BITS-1:0]                          o_bank_col,
    output logic [gc_pkg::WORD_BITS-1:0]                         o_bank_write_data,
    // bank return and read data
    output logic [gc_pkg::NUM_BANKS-1:0]                         o_bank_ren,
    input  wire logic [gc_pkg::NUM_BANKS-1:0]                    i_bank_rdata_valid,
    input  wire logic [gc_pkg::NUM_BANKS-1:0][gc_pkg::WORD_BITS-1:0] i_bank_rdata,
    output logic                                                 o_read_data_valid,
    output logic [gc_pkg::WORD_BITS-1:0]                         o_read_data
);

    gc_pkg::gc_cmd_t   cmd;
    logic              head_valid;
    gc_pkg::gc_entry_t head;
    logic              head_pop;
    logic              order_push;
    gc_pkg::bank_t     order_bank;
    logic              order_full;

    assign cmd.op   = i_cmd_op;
    assign cmd.bank = i_cmd_bank;
    assign cmd.row  = i_cmd_row;
    assign cmd.col  = i_cmd_col;

    gc_queue_if q_if ();

    gc_request_intake #(.QUEUE_DEPTH(QUEUE_DEPTH)) gc_request_intake_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_cmd_valid  (i_cmd_valid),
        .i_cmd        (cmd),
        .i_write_data (i_write_data),
        .o_ready      (o_ready),
        .q            (q_if.intake)
    );

    gc_scheduler #(.SCHED_DEPTH(SCHED_DEPTH)) gc_scheduler_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_pop        (head_pop),
        .q            (q_if.sched),
        .o_head_valid (head_valid),
        .o_head       (head)
    );

    gc_bank_dispatch gc_bank_dispatch_i (
        .i_head_valid      (head_valid),
        .i_head            (head),
        .i_order_full      (order_full),
        .i_bank_ready      (i_bank_ready),
        .o_pop             (head_pop),
        .o_order_push      (order_push),
        .o_order_bank      (order_bank),
        .o_bank_cmd_valid  (o_bank_cmd_valid),
        .o_bank_op         (o_bank_op),
        .o_bank_row        (o_bank_row),
        .o_bank_col        (o_bank_col),
        .o_bank_write_data (o_bank_write_data)
    );

    gc_read_return #(.ORDER_DEPTH(ORDER_DEPTH)) gc_read_return_i (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_order_push       (order_push),
        .i_order_bank       (order_bank),
        .i_bank_rdata_valid (i_bank_rdata_valid),
        .i_bank_rdata       (i_bank_rdata),
        .o_order_full       (order_full),
        .o_bank_ren         (o_bank_ren),
        .o_read_data_valid  (o_read_data_valid),
        .o_read_data        (o_read_data)
    );

endmodule

`default_nettype wire

// File: logic/gc_pkg.sv
`default_nettype none

package gc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // address and data widths
    ////////////////////////////////////////////////////////////////////////////
    localparam int ROW_BITS  = 8;
    localparam int COL_BITS  = 6;
    localparam int BANK_BITS = 2;
    localparam int NUM_BANKS = 1 << BANK_BITS;
    localparam int WORD_BITS = 32;

    // default queue depths for the top level
    localparam int QUEUE_DEPTH_DEF = 8;
    localparam int SCHED_DEPTH_DEF = 2;
    localparam int ORDER_DEPTH_DEF = 8;

    ////////////////////////////////////////////////////////////////////////////
    // command types
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic
    {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_e;

    typedef logic [BANK_BITS-1:0] bank_t;

    typedef struct packed
    {
        op_e                 op;
        bank_t               bank;
        logic [ROW_BITS-1:0] row;
        logic [COL_BITS-1:0] col;
    } gc_cmd_t;

    // write data rides with its command, zero for reads
    typedef struct packed
    {
        gc_cmd_t              cmd;
        logic [WORD_BITS-1:0] data;
    } gc_entry_t;

endpackage

`default_nettype wire

// File: logic/gc_queue_if.sv
`timescale 1ns/1ps
`default_nettype none

interface gc_queue_if;

    // read queue head
    logic              rd_valid;
    gc_pkg::gc_cmd_t   rd_cmd;
    logic              rd_pop;

    // write queue head, carries its data
    logic              wr_valid;
    gc_pkg::gc_entry_t wr_entry;
    logic              wr_pop;

    // write-flush state after a hazard
    logic              flush;

    modport intake
    (
        output rd_valid, rd_cmd, wr_valid, wr_entry, flush,
        input  rd_pop, wr_pop
    );

    modport sched
    (
        input  rd_valid, rd_cmd, wr_valid, wr_entry, flush,
        output rd_pop, wr_pop
    );

endinterface

`default_nettype wire

// File: logic/gc_read_return.sv
`timescale 1ns/1ps
`default_nettype none

module gc_read_return #(
    parameter int ORDER_DEPTH = 8
) (
    input  wire logic                                            i_clk,
    input  wire logic                                            i_rst_n,
    input  wire logic                                            i_order_push,
    input  wire gc_pkg::bank_t                                   i_order_bank,
    input  wire logic [gc_pkg::NUM_BANKS-1:0]                    i_bank_rdata_valid,
    input  wire logic [gc_pkg::NUM_BANKS-1:0][gc_pkg::WORD_BITS-1:0] i_bank_rdata,
    output logic                                                 o_order_full,
    output logic [gc_pkg::NUM_BANKS-1:0]                         o_bank_ren,
    output logic                                                 o_read_data_valid,
    output logic [gc_pkg::WORD_BITS-1:0]                         o_read_data
);

    gc_pkg::bank_t head_bank;
    logic          order_empty;
    logic          take;

    // banks in the order their reads were dispatched
    gc_fifo #(
        .T     (gc_pkg::bank_t),
        .DEPTH (ORDER_DEPTH)
    ) order_fifo_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (i_order_push),
        .i_data  (i_order_bank),
        .i_pop   (take),
        .o_data  (head_bank),
        .o_empty (order_empty),
        .o_full  (o_order_full)
    );

    // only the oldest outstanding bank may return
    always_comb
    begin
        for (int b = 0; b < gc_pkg::NUM_BANKS; b++)
        begin
            o_bank_ren[b] = !order_empty && (head_bank == gc_pkg::bank_t'(b));
        end
    end

    assign take = |(o_bank_ren & i_bank_rdata_valid);

    ////////////////////////////////////////////////////////////////////////////
    // read data register, one cycle after the bank transfer
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_read_data_valid <= 1'b0;
            o_read_data       <= '0;
        end
        else
        begin
            o_read_data_valid <= take;
            if (take)
            begin
                o_read_data <= i_bank_rdata[head_bank];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/gc_request_intake.sv
`timescale 1ns/1ps
`default_nettype none

module gc_request_intake #(
    parameter int QUEUE_DEPTH = 8
) (
    input  wire logic                           i_clk,
    input  wire logic                           i_rst_n,
    input  wire logic                           i_cmd_valid,
    input  wire gc_pkg::gc_cmd_t                i_cmd,
    input  wire logic [gc_pkg::WORD_BITS-1:0]   i_write_data,
    output logic                                o_ready,
    gc_queue_if.intake                          q
);

    localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    logic              accept;
    logic              rd_push;
    logic              wr_push;
    logic              rd_empty;
    logic              rd_full;
    gc_pkg::gc_cmd_t   rd_head;

    gc_pkg::gc_entry_t      wq_mem [QUEUE_DEPTH];
    logic [QUEUE_DEPTH-1:0] wq_valid;
    logic [PTR_BITS-1:0]    wq_wr_ptr;
    logic [PTR_BITS-1:0]    wq_rd_ptr;
    logic                   wq_full;
    logic                   wq_empty;
    logic                   raw_hit;
    logic                   flush;

    assign o_ready = !rd_full && !wq_full && !flush;
    assign accept  = i_cmd_valid && o_ready;
    assign rd_push = accept && (i_cmd.op == gc_pkg::OP_READ);
    assign wr_push = accept && (i_cmd.op == gc_pkg::OP_WRITE);

    ////////////////////////////////////////////////////////////////////////////
    // read queue
    ////////////////////////////////////////////////////////////////////////////
    gc_fifo #(
        .T     (gc_pkg::gc_cmd_t),
        .DEPTH (QUEUE_DEPTH)
    ) rd_fifo_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (rd_push),
        .i_data  (i_cmd),
        .i_pop   (q.rd_pop),
        .o_data  (rd_head),
        .o_empty (rd_empty),
        .o_full  (rd_full)
    );

    assign q.rd_valid = !rd_empty;
    assign q.rd_cmd   = rd_head;

    ////////////////////////////////////////////////////////////////////////////
    // write queue, every slot visible for the hazard compare
    ////////////////////////////////////////////////////////////////////////////
    // slots stay contiguous, so the pointer slots tell full and empty
    assign wq_full  = wq_valid[wq_wr_ptr];
    assign wq_empty = !wq_valid[wq_rd_ptr];

    assign q.wr_valid = !wq_empty;
    assign q.wr_entry = wq_mem[wq_rd_ptr];

    always_ff @(posedge i_clk)
    begin
        if (wr_push)
        begin
            wq_mem[wq_wr_ptr].cmd  <= i_cmd;
            wq_mem[wq_wr_ptr].data <= i_write_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wq_valid  <= '0;
            wq_wr_ptr <= '0;
            wq_rd_ptr <= '0;
        end
        else
        begin
            if (wr_push)
            begin
                wq_valid[wq_wr_ptr] <= 1'b1;
                wq_wr_ptr <= (wq_wr_ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : wq_wr_ptr + 1'b1;
            end
            if (q.wr_pop)
            begin
                wq_valid[wq_rd_ptr] <= 1'b0;
                wq_rd_ptr <= (wq_rd_ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : wq_rd_ptr + 1'b1;
            end
        end
    end

    // read-after-write check on bank, row and col
    always_comb
    begin
        raw_hit = 1'b0;
        for (int i = 0; i < QUEUE_DEPTH; i++)
        begin
            if (wq_valid[i] && wq_mem[i].cmd.bank == i_cmd.bank
                && wq_mem[i].cmd.row == i_cmd.row && wq_mem[i].cmd.col == i_cmd.col)
            begin
                raw_hit = 1'b1;
            end
        end
    end

    // flush holds until the write queue drains
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            flush <= 1'b0;
        end
        else if (rd_push && raw_hit)
        begin
            flush <= 1'b1;
        end
        else if (wq_empty)
        begin
            flush <= 1'b0;
        end
    end

    assign q.flush = flush;

endmodule

`default_nettype wire

// File: logic/gc_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module gc_scheduler #(
    parameter int SCHED_DEPTH = 2
) (
    input  wire logic          i_clk,
    input  wire logic          i_rst_n,
    input  wire logic          i_pop,
    gc_queue_if.sched          q,
    output logic               o_head_valid,
    output gc_pkg::gc_entry_t  o_head
);

    logic              sched_full;
    logic              sched_empty;
    logic              take_rd;
    logic              take_wr;
    gc_pkg::gc_entry_t cand;

    // pending writes win during a flush, otherwise reads go first
    assign take_wr = !sched_full && q.wr_valid && (q.flush || !q.rd_valid);
    assign take_rd = !sched_full && q.rd_valid && !(q.flush && q.wr_valid);

    assign q.wr_pop = take_wr;
    assign q.rd_pop = take_rd;

    always_comb
    begin
        if (take_wr)
        begin
            cand = q.wr_entry;
        end
        else
        begin
            cand.cmd  = q.rd_cmd;
            cand.data = '0;
        end
    end

    gc_fifo #(
        .T     (gc_pkg::gc_entry_t),
        .DEPTH (SCHED_DEPTH)
    ) sched_fifo_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (take_rd || take_wr),
        .i_data  (cand),
        .i_pop   (i_pop),
        .o_data  (o_head),
        .o_empty (sched_empty),
        .o_full  (sched_full)
    );

    assign o_head_valid = !sched_empty;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# compile the testbench with Verilator and run it from the project root
# the exit status is the simulator's, so a $fatal in the run fails the script

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f \
    --top-module tb_gc_top -o tb_gc_top \
    && ./obj_dir/tb_gc_top \
    || { echo "simulation run failed"; exit 1; }

// File: sim/gc_bank_model.sv
`timescale 1ns/1ps
`default_nettype none

module gc_bank_model (
    input  wire logic                                                i_clk,
    input  wire logic                                                i_rst_n,
    input  wire logic                                                i_hold,
    input  wire logic [gc_pkg::NUM_BANKS-1:0]                        i_cmd_valid,
    input  wire gc_pkg::op_e                                         i_op,
    input  wire logic [gc_pkg::ROW_BITS-1:0]                         i_row,
    input  wire logic [gc_pkg::COL_BITS-1:0]                         i_col,
    input  wire logic [gc_pkg::WORD_BITS-1:0]                        i_write_data,
    input  wire logic [gc_pkg::NUM_BANKS-1:0]                        i_ren,
    output logic [gc_pkg::NUM_BANKS-1:0]                             o_ready,
    output logic [gc_pkg::NUM_BANKS-1:0]                             o_rdata_valid,
    output logic [gc_pkg::NUM_BANKS-1:0][gc_pkg::WORD_BITS-1:0]      o_rdata
);

    localparam int ADDR_BITS = gc_pkg::BANK_BITS + gc_pkg::ROW_BITS + gc_pkg::COL_BITS;

    // storage keyed by {bank, row, col}
    logic [gc_pkg::WORD_BITS-1:0] mem [logic [ADDR_BITS-1:0]];
    logic [gc_pkg::WORD_BITS-1:0] rd_q [gc_pkg::NUM_BANKS][$];
    int unsigned                  wait_cnt [gc_pkg::NUM_BANKS];
    logic [ADDR_BITS-1:0]         addr;

    initial
    begin
        void'($urandom(32'h89de2d2f));
    end

    // unwritten locations read back a word built from the whole address
    function automatic logic [gc_pkg::WORD_BITS-1:0] fill_word(input logic [ADDR_BITS-1:0] a);
        return {16'hdead, a};
    endfunction

    always @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_ready       <= '0;
            o_rdata_valid <= '0;
            o_rdata       <= '0;
            for (int b = 0; b < gc_pkg::NUM_BANKS; b++)
                wait_cnt[b] <= 0;
        end
        else
        begin
            for (int b = 0; b < gc_pkg::NUM_BANKS; b++)
            begin
                addr = {gc_pkg::bank_t'(b), i_row, i_col};
                // ready drops about one cycle in four, always while held
                o_ready[b] <= !i_hold && (($urandom % 4) != 0);
                if (i_cmd_valid[b])
                begin
                    if (i_op == gc_pkg::OP_WRITE)
                        mem[addr] = i_write_data;
                    else
                        rd_q[b].push_back(mem.exists(addr) ? mem[addr] : fill_word(addr));
                end
                // return side, head of the bank queue after a random delay
                if (o_rdata_valid[b] && i_ren[b])
                begin
                    rd_q[b].delete(0);
                    o_rdata_valid[b] <= 1'b0;
                    wait_cnt[b]      <= $urandom % 5;
                end
                else if (!o_rdata_valid[b] && rd_q[b].size() > 0)
                begin
                    if (wait_cnt[b] == 0)
                    begin
                        o_rdata_valid[b] <= 1'b1;
                        o_rdata[b]       <= rd_q[b][0];
                    end
                    else
                        wait_cnt[b] <= wait_cnt[b] - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/gc_vectors.txt
// op(0 read, 1 write) bank row col write_data expected_read_data hold_banks
// lines with hold_banks set form one group, issued while every bank is stalled
1 0 10 01 11110000 00000000 0
1 1 20 02 22220000 00000000 0
1 2 30 03 33330000 00000000 0
1 3 40 04 44440000 00000000 0
0 0 10 01 00000000 11110000 0
0 1 20 02 00000000 22220000 0
0 2 30 03 00000000 33330000 0
0 3 40 04 00000000 44440000 0
0 2 55 3f 00000000 dead957f 0
0 0 10 01 00000000 11110000 0
// read priority group
1 1 21 05 a0000001 00000000 1
1 2 31 06 a0000002 00000000 1
1 3 41 07 a0000003 00000000 1
1 0 11 08 a0000004 00000000 1
0 3 40 04 00000000 44440000 1
0 1 20 02 00000000 22220000 1
0 2 31 06 00000000 a0000002 0
// hazard group, last read hits the pending write
1 0 12 09 b0000001 00000000 1
1 1 22 0a b0000002 00000000 1
1 2 30 03 b0000003 00000000 1
0 2 30 03 00000000 b0000003 1
0 0 11 08 00000000 a0000004 0
0 3 00 00 00000000 deadc000 0
0 1 22 0a 00000000 b0000002 0

// File: sim/tb_gc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gc_top;

    localparam int NUM_VEC  = 24;
    localparam int NUM_COLS = 7;
    localparam int NB       = gc_pkg::NUM_BANKS;
    // vector file columns
    localparam int C_OP     = 0;
    localparam int C_BANK   = 1;
    localparam int C_ROW    = 2;
    localparam int C_COL    = 3;
    localparam int C_WDATA  = 4;
    localparam int C_EXP    = 5;
    localparam int C_HOLD   = 6;

    logic                              i_clk;
    logic                              i_rst_n;
    logic                              cmd_valid;
    gc_pkg::op_e                       cmd_op;
    gc_pkg::bank_t                     cmd_bank;
    logic [gc_pkg::ROW_BITS-1:0]       cmd_row;
    logic [gc_pkg::COL_BITS-1:0]       cmd_col;
    logic [gc_pkg::WORD_BITS-1:0]      write_data;
    logic                              ready;
    logic [NB-1:0]                     bank_ready;
    logic [NB-1:0]                     bank_cmd_valid;
    gc_pkg::op_e                       bank_op;
    logic [gc_pkg::ROW_BITS-1:0]       bank_row;
    logic [gc_pkg::COL_BITS-1:0]       bank_col;
    logic [gc_pkg::WORD_BITS-1:0]      bank_write_data;
    logic [NB-1:0]                     bank_ren;
    logic [NB-1:0]                     bank_rdata_valid;
    logic [NB-1:0][gc_pkg::WORD_BITS-1:0] bank_rdata;
    logic                              read_valid;
    logic [gc_pkg::WORD_BITS-1:0]      read_data;
    logic                              hold;

    logic [31:0] vec [NUM_VEC*NUM_COLS];
    int          pend[$];
    int          exp_rd[$];
    int          exp_order[$];
    int          held_wr[$];
    int          held_rd[$];
    bit          held;
    bit          flush_m;
    int          sched_fill;
    bit          last_take;
    logic [31:0] last_word;

    gc_global_controller gc_global_controller_i (
        .i_clk (i_clk), .i_rst_n (i_rst_n),
        .i_cmd_valid (cmd_valid), .i_cmd_op (cmd_op), .i_cmd_bank (cmd_bank),
        .i_cmd_row (cmd_row), .i_cmd_col (cmd_col), .i_write_data (write_data),
        .o_ready (ready), .i_bank_ready (bank_ready), .o_bank_cmd_valid (bank_cmd_valid),
        .o_bank_op (bank_op), .o_bank_row (bank_row), .o_bank_col (bank_col),
        .o_bank_write_data (bank_write_data), .o_bank_ren (bank_ren),
        .i_bank_rdata_valid (bank_rdata_valid), .i_bank_rdata (bank_rdata),
        .o_read_data_valid (read_valid), .o_read_data (read_data)
    );

    gc_bank_model bank_model_i (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_hold (hold),
        .i_cmd_valid (bank_cmd_valid), .i_op (bank_op), .i_row (bank_row),
        .i_col (bank_col), .i_write_data (bank_write_data), .i_ren (bank_ren),
        .o_ready (bank_ready), .o_rdata_valid (bank_rdata_valid), .o_rdata (bank_rdata)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    function automatic logic [31:0] field(input int idx, input int c);
        return vec[idx*NUM_COLS + c];
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            stop_run($sformatf("Mismatch on %s: got 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    function automatic bit same_addr(input int a, input int b);
        return field(a, C_BANK) == field(b, C_BANK) && field(a, C_ROW) == field(b, C_ROW)
               && field(a, C_COL) == field(b, C_COL);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // monitor, sampled mid-cycle
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_dispatch();
        int b;
        int idx;
        int pos;
        b   = 0;
        idx = -1;
        pos = -1;
        check("o_bank_cmd_valid onehot", 32'($onehot(bank_cmd_valid)), 32'd1);
        for (int k = 0; k < NB; k++)
            if (bank_cmd_valid[k]) b = k;
        check("i_bank_ready", 32'(bank_ready[b]), 32'd1);
        if (exp_order.size() > 0)
            idx = exp_order.pop_front();
        else
            // reads keep their order, writes keep theirs
            foreach (pend[k])
                if (idx < 0 && field(pend[k], C_OP) == 32'(bank_op)) idx = pend[k];
        foreach (pend[k])
            if (pos < 0 && pend[k] == idx) pos = k;
        if (pos < 0)
            stop_run("a command was dispatched that matches no pending request");
        else
        begin
            pend.delete(pos);
            check("dispatch bank", 32'(b), field(idx, C_BANK));
            check("o_bank_op", 32'(bank_op), field(idx, C_OP));
            check("o_bank_row", 32'(bank_row), field(idx, C_ROW));
            check("o_bank_col", 32'(bank_col), field(idx, C_COL));
            check("o_bank_write_data", bank_write_data, field(idx, C_WDATA));
        end
    endtask

    always @(negedge i_clk)
    begin
        if (i_rst_n)
        begin
            if (|bank_cmd_valid)
                check_dispatch();
            // a bank transfer shows up on the read data one cycle later
            check("o_read_data_valid", 32'(read_valid), 32'(last_take));
            if (read_valid)
            begin
                check("o_read_data", read_data, last_word);
                if (exp_rd.size() == 0)
                    stop_run("read data came back with no read outstanding");
                else
                    check("o_read_data", read_data, field(exp_rd.pop_front(), C_EXP));
            end
            last_take = |(bank_ren & bank_rdata_valid);
            for (int k = 0; k < NB; k++)
                if (bank_ren[k]) last_word = bank_rdata[k];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////
    task automatic wait_drain();
        @(negedge i_clk);
        while (pend.size() > 0 || exp_rd.size() > 0)
            @(negedge i_clk);
    endtask

    task automatic hold_banks();
        wait_drain();
        @(posedge i_clk);
        hold <= 1'b1;
        @(posedge i_clk);
        held       = 1'b1;
        flush_m    = 1'b0;
        sched_fill = 0;
        held_wr.delete();
        held_rd.delete();
    endtask

    // scheduled entries first, then the flush or read-priority order
    task automatic release_banks();
        if (flush_m)
        begin
            check("o_ready during flush", 32'(ready), 32'd0);
            foreach (held_wr[k]) exp_order.push_back(held_wr[k]);
            foreach (held_rd[k]) exp_order.push_back(held_rd[k]);
        end
        else
        begin
            foreach (held_rd[k]) exp_order.push_back(held_rd[k]);
            foreach (held_wr[k]) exp_order.push_back(held_wr[k]);
        end
        @(posedge i_clk);
        hold <= 1'b0;
        held = 1'b0;
        wait_drain();
        check("o_ready after drain", 32'(ready), 32'd1);
    endtask

    task automatic issue(input int idx);
        bit hit;
        hit = 1'b0;
        pend.push_back(idx);
        if (field(idx, C_OP) == 0)
            exp_rd.push_back(idx);
        if (held && sched_fill < gc_pkg::SCHED_DEPTH_DEF)
        begin
            exp_order.push_back(idx);
            sched_fill++;
        end
        else if (held && field(idx, C_OP) != 0)
            held_wr.push_back(idx);
        else if (held)
        begin
            foreach (held_wr[k])
                if (same_addr(held_wr[k], idx)) hit = 1'b1;
            held_rd.push_back(idx);
            flush_m = flush_m | hit;
        end
        @(posedge i_clk);
        cmd_valid  <= 1'b1;
        cmd_op     <= gc_pkg::op_e'(1'(field(idx, C_OP)));
        cmd_bank   <= gc_pkg::bank_t'(field(idx, C_BANK));
        cmd_row    <= gc_pkg::ROW_BITS'(field(idx, C_ROW));
        cmd_col    <= gc_pkg::COL_BITS'(field(idx, C_COL));
        write_data <= field(idx, C_WDATA);
        @(negedge i_clk);
        while (!ready)
            @(negedge i_clk);
        @(posedge i_clk);
        cmd_valid <= 1'b0;
        if (hit)
        begin
            @(negedge i_clk);
            check("o_ready after hazard read", 32'(ready), 32'd0);
        end
    endtask

    initial
    begin
        i_rst_n    = 1'b0;
        cmd_valid  = 1'b0;
        cmd_op     = gc_pkg::OP_READ;
        cmd_bank   = '0;
        cmd_row    = '0;
        cmd_col    = '0;
        write_data = '0;
        hold       = 1'b0;
        held       = 1'b0;
        last_take  = 1'b0;
        last_word  = '0;
        $readmemh("sim/gc_vectors.txt", vec);
        repeat (3) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);
        check("o_ready", 32'(ready), 32'd1);
        check("o_bank_cmd_valid", 32'(bank_cmd_valid), 32'd0);
        check("o_bank_ren", 32'(bank_ren), 32'd0);
        check("o_read_data_valid", 32'(read_valid), 32'd0);
        check("o_read_data", read_data, 32'd0);
        for (int i = 0; i < NUM_VEC; i++)
        begin
            if (field(i, C_HOLD) != 0 && !held)
                hold_banks();
            else if (field(i, C_HOLD) == 0 && held)
                release_banks();
            issue(i);
        end
        if (held)
            release_banks();
        wait_drain();
        $display("All tests passed!");
        $finish;
    end

    // watchdog, 200 cycles per vector line
    initial
    begin
        repeat (NUM_VEC * 200) @(posedge i_clk);
        stop_run("timeout: the run did not finish in the allowed number of cycles");
    end

endmodule

`default_nettype wire

// File: verilog.f
logic/gc_pkg.sv
logic/gc_queue_if.sv
logic/gc_fifo.sv
logic/gc_request_intake.sv
logic/gc_scheduler.sv
logic/gc_bank_dispatch.sv
logic/gc_read_return.sv
logic/gc_global_controller.sv
sim/gc_bank_model.sv
sim/tb_gc_top.sv
